/* Bender.yml */
package:
  name: afu_shell

sources:
  - files:
      - src/afu_pkg.sv
      - src/sync_fifo.sv
      - src/host_rx_stage.sv
      - src/mmio_cra_bridge.sv
      - src/kernel_csr_block.sv
      - src/afu_top.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/afu_top_tb.sv

/* list.f */
+incdir+verif
src/afu_pkg.sv
src/sync_fifo.sv
src/host_rx_stage.sv
src/mmio_cra_bridge.sv
src/kernel_csr_block.sv
src/afu_top.sv
verif/afu_top_tb.sv

/* src/afu_pkg.sv */
/*
 * AFU shared definitions
 * Widths, MMIO map constants and the packed structs carried between the
 * host receive stage, the MMIO bridge and the kernel CRA port
 */
package afu_pkg;

    // ==============================
    // Widths
    // ==============================

    // MMIO addresses count 32-bit words, as on the host side
    localparam int MMIO_ADDR_W = 16;
    localparam int MMIO_TID_W  = 9;
    // All MMIO and CRA data is 64 bits wide
    localparam int CSR_DATA_W  = 64;
    // CRA addresses count bytes
    localparam int CRA_ADDR_W  = 30;
    localparam int CRA_BE_W    = 8;

    typedef logic [MMIO_ADDR_W-1:0] mmio_addr_t;
    typedef logic [MMIO_TID_W-1:0]  mmio_tid_t;
    typedef logic [CSR_DATA_W-1:0]  csr_data_t;

    // ==============================
    // Address map and constants
    // ==============================

    // Word addresses below this belong to the feature header region
    localparam mmio_addr_t KERNEL_CSR_BASE = 16'h0100;
    // Feature header: AFU type in the top nibble, end-of-list flag set
    localparam csr_data_t  AFU_DFH         = 64'h1000_0100_0000_0000;
    // Read-only kernel register 0
    localparam csr_data_t  KERNEL_VERSION  = 64'h0000_0000_0002_0001;

    // ==============================
    // Bus structs
    // ==============================

    // Host receive port; rsp_valid marks host-memory traffic on the same channel
    typedef struct packed {
        logic       mmio_rd_valid;
        logic       mmio_wr_valid;
        logic       rsp_valid;
        mmio_addr_t addr;
        mmio_tid_t  tid;
        csr_data_t  data;
    } host_rx_t;

    typedef struct packed {
        logic       is_write;
        mmio_addr_t addr;
        mmio_tid_t  tid;
        csr_data_t  data;
    } mmio_req_t;

    // Host transmit port, one read response per valid cycle
    typedef struct packed {
        logic      valid;
        mmio_tid_t tid;
        csr_data_t data;
    } mmio_rsp_t;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [CRA_ADDR_W-1:0] address;
        logic [CRA_BE_W-1:0]   byteenable;
        csr_data_t             writedata;
    } cra_cmd_t;

    typedef struct packed {
        logic      waitrequest;
        logic      readdatavalid;
        csr_data_t readdata;
    } cra_rsp_t;

endpackage

/* src/afu_top.sv */
/*
 * AFU top level
 * Host receive stage, MMIO to CRA bridge and kernel register block
 * on the single pClk domain
 */
`timescale 1ns/1ps

module afu_top #(
    parameter int MMIO_FIFO_DEPTH = 16,
    parameter int NUM_KERNEL_CSRS = 8,
    parameter int KERNEL_RD_DEPTH = 4
) (
    input  logic                pClk,
    input  logic                reset,
    input  afu_pkg::host_rx_t   rx,
    output afu_pkg::mmio_rsp_t  tx
);

    // Everything past the receive stage runs from the delayed reset
    logic               rst_q;
    logic               req_valid;
    afu_pkg::mmio_req_t req;
    afu_pkg::cra_cmd_t  cra_cmd;
    afu_pkg::cra_rsp_t  cra_rsp;

    host_rx_stage u_rx (
        .pClk      (pClk),
        .reset     (reset),
        .rx        (rx),
        .rst_q     (rst_q),
        .req_valid (req_valid),
        .req       (req)
    );

    mmio_cra_bridge #(
        .MMIO_FIFO_DEPTH (MMIO_FIFO_DEPTH)
    ) u_bridge (
        .pClk      (pClk),
        .reset     (rst_q),
        .req_valid (req_valid),
        .req       (req),
        .cra_cmd   (cra_cmd),
        .cra_rsp   (cra_rsp),
        .mmio_rsp  (tx)
    );

    kernel_csr_block #(
        .NUM_KERNEL_CSRS (NUM_KERNEL_CSRS),
        .KERNEL_RD_DEPTH (KERNEL_RD_DEPTH)
    ) u_kernel (
        .pClk    (pClk),
        .reset   (rst_q),
        .cra_cmd (cra_cmd),
        .cra_rsp (cra_rsp)
    );

endmodule

/* src/host_rx_stage.sv */
/*
 * Host receive stage
 * Delays the reset through two flops and registers the receive port once.
 * Only MMIO reads and writes pass on; host-memory responses are dropped.
 */
`timescale 1ns/1ps

module host_rx_stage (
    input  logic                pClk,
    input  logic                reset,
    input  afu_pkg::host_rx_t   rx,
    output logic                rst_q,
    output logic                req_valid,
    output afu_pkg::mmio_req_t  req
);

    logic                rst_meta;
    logic                rd_valid_q;
    logic                wr_valid_q;
    afu_pkg::mmio_addr_t addr_q;
    afu_pkg::mmio_tid_t  tid_q;
    afu_pkg::csr_data_t  data_q;

    // ==============================
    // Reset pipeline
    // ==============================

    // Downstream logic sees reset drop two cycles after the input does
    always_ff @(posedge pClk)
    begin
        rst_meta <= reset;
        rst_q    <= rst_meta;
    end

    // ==============================
    // Receive register
    // ==============================

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end
        else
        begin
            rd_valid_q <= rx.mmio_rd_valid;
            wr_valid_q <= rx.mmio_wr_valid;
        end
    end

    // Payload only loads on MMIO traffic so host responses never disturb it
    always_ff @(posedge pClk)
    begin
        if (rx.mmio_rd_valid || rx.mmio_wr_valid)
        begin
            addr_q <= rx.addr;
            tid_q  <= rx.tid;
            data_q <= rx.data;
        end
    end

    assign req_valid    = rd_valid_q | wr_valid_q;
    assign req.is_write = wr_valid_q;
    assign req.addr     = addr_q;
    assign req.tid      = tid_q;
    assign req.data     = data_q;

    // The receive channel carries at most one of read, write or host response
    a_one_kind: assert property (@(posedge pClk) disable iff (reset)
        $onehot0({rx.mmio_rd_valid, rx.mmio_wr_valid, rx.rsp_valid}));

endmodule

/* src/kernel_csr_block.sv */
/*
 * Kernel control registers
 * 64-bit register file on the CRA port. Register 0 holds the version,
 * the rest are read/write with byte enables. Read data is queued and
 * returned in order; waitrequest rises while the read queue is full.
 */
`timescale 1ns/1ps

module kernel_csr_block #(
    parameter int NUM_KERNEL_CSRS = 8,
    parameter int KERNEL_RD_DEPTH = 4
) (
    input  logic               pClk,
    input  logic               reset,
    input  afu_pkg::cra_cmd_t  cra_cmd,
    output afu_pkg::cra_rsp_t  cra_rsp
);

    localparam int IDX_W = (NUM_KERNEL_CSRS > 1) ? $clog2(NUM_KERNEL_CSRS) : 1;

    // Register 0 is a constant, so storage starts at 1
    afu_pkg::csr_data_t csr_q [1:NUM_KERNEL_CSRS-1];
    logic [IDX_W-1:0]   reg_sel;
    logic               in_range;
    logic               rd_accept;
    logic               wr_accept;
    afu_pkg::csr_data_t rd_value;
    afu_pkg::csr_data_t rd_head;
    logic               rd_empty;
    logic               rd_full;

    // Registers sit on 8-byte boundaries
    assign reg_sel   = cra_cmd.address[3 +: IDX_W];
    assign in_range  = (cra_cmd.address[afu_pkg::CRA_ADDR_W-1:3] < NUM_KERNEL_CSRS);
    assign rd_accept = cra_cmd.read & ~rd_full;
    assign wr_accept = cra_cmd.write & ~rd_full;

    always_comb
    begin
        if (!in_range)
            rd_value = '0;
        else if (reg_sel == '0)
            rd_value = afu_pkg::KERNEL_VERSION;
        else
            rd_value = csr_q[reg_sel];
    end

    // ==============================
    // Register writes
    // ==============================

    // Writes to register 0 or past the end are ignored
    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            for (int i = 1; i < NUM_KERNEL_CSRS; i++)
                csr_q[i] <= '0;
        end
        else if (wr_accept && in_range && reg_sel != '0)
        begin
            for (int b = 0; b < afu_pkg::CRA_BE_W; b++)
            begin
                if (cra_cmd.byteenable[b])
                    csr_q[reg_sel][8*b +: 8] <= cra_cmd.writedata[8*b +: 8];
            end
        end
    end

    // ==============================
    // Read queue
    // ==============================

    // Data is captured at acceptance and drained one entry per cycle
    sync_fifo #(
        .payload_t (afu_pkg::csr_data_t),
        .DEPTH     (KERNEL_RD_DEPTH)
    ) u_rd_fifo (
        .pClk      (pClk),
        .reset     (reset),
        .push      (rd_accept),
        .push_data (rd_value),
        .pop       (~rd_empty),
        .pop_data  (rd_head),
        .empty     (rd_empty),
        .full      (rd_full)
    );

    assign cra_rsp.waitrequest   = rd_full;
    assign cra_rsp.readdatavalid = ~rd_empty;
    assign cra_rsp.readdata      = rd_head;

    a_no_rd_wr: assert property (@(posedge pClk) disable iff (reset)
        !(cra_cmd.read && cra_cmd.write));

endmodule

/* src/mmio_cra_bridge.sv */
/*
 * MMIO to CRA bridge
 * Queues host MMIO requests, answers the feature header region locally
 * and turns kernel-region requests into CRA commands.
 * Read responses return to the host in request order with their tids.
 */
`timescale 1ns/1ps

module mmio_cra_bridge #(
    parameter int MMIO_FIFO_DEPTH = 16
) (
    input  logic                pClk,
    input  logic                reset,
    input  logic                req_valid,
    input  afu_pkg::mmio_req_t  req,
    output afu_pkg::cra_cmd_t   cra_cmd,
    input  afu_pkg::cra_rsp_t   cra_rsp,
    output afu_pkg::mmio_rsp_t  mmio_rsp
);

    afu_pkg::mmio_req_t               head;
    logic                             req_empty;
    logic                             req_pop;
    logic                             head_is_kernel;
    afu_pkg::mmio_addr_t              kernel_off;
    afu_pkg::csr_data_t               hdr_data;
    logic                             hdr_rd_take;
    logic                             hdr_wr_drop;
    logic                             cmd_rd_q;
    logic                             cmd_wr_q;
    logic [afu_pkg::CRA_ADDR_W-1:0]   cmd_addr_q;
    afu_pkg::csr_data_t               cmd_data_q;
    afu_pkg::mmio_tid_t               cmd_tid_q;
    logic                             cmd_busy;
    logic                             cmd_accept;
    logic                             cmd_load;
    afu_pkg::mmio_tid_t               tid_head;
    logic                             tid_empty;
    logic                             rd_outstanding;
    logic                             rsp_valid_q;
    afu_pkg::mmio_tid_t               rsp_tid_q;
    afu_pkg::csr_data_t               rsp_data_q;

    // ==============================
    // Request queue
    // ==============================

    // No back-pressure toward the host; its credit limit bounds the depth
    sync_fifo #(
        .payload_t (afu_pkg::mmio_req_t),
        .DEPTH     (MMIO_FIFO_DEPTH)
    ) u_req_fifo (
        .pClk      (pClk),
        .reset     (reset),
        .push      (req_valid),
        .push_data (req),
        .pop       (req_pop),
        .pop_data  (head),
        .empty     (req_empty),
        .full      ()
    );

    // Decode of the head entry
    assign head_is_kernel = (head.addr >= afu_pkg::KERNEL_CSR_BASE);
    assign kernel_off     = head.addr - afu_pkg::KERNEL_CSR_BASE;
    // Only word 0 of the header region holds anything
    assign hdr_data       = (head.addr == '0) ? afu_pkg::AFU_DFH : '0;

    // A kernel read is in flight while it waits on the port or in the tid queue
    assign rd_outstanding = cmd_rd_q | ~tid_empty;

    // Header reads wait for kernel reads ahead of them to drain, keeping order
    assign hdr_rd_take = ~req_empty & ~head_is_kernel & ~head.is_write & ~rd_outstanding;
    // Header writes have no target and leave at once
    assign hdr_wr_drop = ~req_empty & ~head_is_kernel & head.is_write;

    // ==============================
    // CRA command register
    // ==============================

    assign cmd_busy   = cmd_rd_q | cmd_wr_q;
    assign cmd_accept = cmd_busy & ~cra_rsp.waitrequest;
    // A new command loads when the register is idle or empties this cycle
    assign cmd_load   = ~req_empty & head_is_kernel & (~cmd_busy | cmd_accept);
    assign req_pop    = cmd_load | hdr_rd_take | hdr_wr_drop;

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            cmd_rd_q <= 1'b0;
            cmd_wr_q <= 1'b0;
        end
        else if (cmd_load)
        begin
            cmd_rd_q <= ~head.is_write;
            cmd_wr_q <= head.is_write;
        end
        else if (cmd_accept)
        begin
            cmd_rd_q <= 1'b0;
            cmd_wr_q <= 1'b0;
        end
    end

    // Word offset from the kernel base becomes a byte address
    always_ff @(posedge pClk)
    begin
        if (cmd_load)
        begin
            cmd_addr_q <= {{(afu_pkg::CRA_ADDR_W - afu_pkg::MMIO_ADDR_W - 2){1'b0}},
                           kernel_off, 2'b00};
            cmd_data_q <= head.data;
            cmd_tid_q  <= head.tid;
        end
    end

    // All accesses are full 64-bit
    assign cra_cmd.read       = cmd_rd_q;
    assign cra_cmd.write      = cmd_wr_q;
    assign cra_cmd.address    = cmd_addr_q;
    assign cra_cmd.byteenable = '1;
    assign cra_cmd.writedata  = cmd_data_q;

    // ==============================
    // Read ordering and response
    // ==============================

    // Each accepted read leaves its tid here until its data comes back
    sync_fifo #(
        .payload_t (afu_pkg::mmio_tid_t),
        .DEPTH     (MMIO_FIFO_DEPTH)
    ) u_tid_fifo (
        .pClk      (pClk),
        .reset     (reset),
        .push      (cmd_accept & cmd_rd_q),
        .push_data (cmd_tid_q),
        .pop       (cra_rsp.readdatavalid),
        .pop_data  (tid_head),
        .empty     (tid_empty),
        .full      ()
    );

    always_ff @(posedge pClk)
    begin
        if (reset)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= cra_rsp.readdatavalid | hdr_rd_take;
    end

    always_ff @(posedge pClk)
    begin
        if (cra_rsp.readdatavalid)
        begin
            rsp_tid_q  <= tid_head;
            rsp_data_q <= cra_rsp.readdata;
        end
        else if (hdr_rd_take)
        begin
            rsp_tid_q  <= head.tid;
            rsp_data_q <= hdr_data;
        end
    end

    assign mmio_rsp.valid = rsp_valid_q;
    assign mmio_rsp.tid   = rsp_tid_q;
    assign mmio_rsp.data  = rsp_data_q;

    // Kernel data and a header answer never compete for the response register
    a_rsp_exclusive: assert property (@(posedge pClk) disable iff (reset)
        !(cra_rsp.readdatavalid && hdr_rd_take));

endmodule

/* src/sync_fifo.sv */
/*
 * Synchronous FIFO
 * First-word-fall-through storage with an occupancy counter.
 * The payload type is a parameter so one body serves every queue.
 */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     pClk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head entry is visible without a pop
    assign pop_data = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

    always_ff @(posedge pClk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A producer that pushes into a full queue has lost track of its credits
    a_no_overflow: assert property (@(posedge pClk) disable iff (reset)
        push |-> !full);

    a_no_underflow: assert property (@(posedge pClk) disable iff (reset)
        pop |-> !empty);

endmodule

/* verif/tb_util.svh */
/*
 * Testbench utilities
 * Xorshift random source, a bounded wait for outstanding read
 * responses and the result counters shared by all tests
 */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

int          err_count    = 0;
int          tests_run    = 0;
int          tests_failed = 0;
logic [31:0] rng_state    = 32'd99259;

// 32-bit xorshift, one step per call
function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Two steps make one 64-bit register value
function automatic afu_pkg::csr_data_t rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = xorshift32();
    lo = xorshift32();
    return {hi, lo};
endfunction

// Waits until every expected response has been seen, or gives up
task automatic wait_drain(input int max_cycles, input string what);
    int n;
    n = 0;
    while (exp_cnt != 0 && n < max_cycles)
    begin
        @(posedge pClk);
        n++;
    end
    if (exp_cnt != 0)
    begin
        $display("Timeout: %0d read responses never arrived during %s", exp_cnt, what);
        err_count++;
        end_run();
    end
endtask

// A test fails if any check fired while it ran
task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (err_count != err_before)
    begin
        tests_failed++;
        $display("Test %0d %s: FAILED with %0d errors", tests_run, name,
                 err_count - err_before);
    end
    else
        $display("Test %0d %s: ok", tests_run, name);
endtask

`endif

/* verif/afu_top_tb.sv */
/*
 * Testbench for afu_top
 * Drives MMIO reads, writes and host-memory responses into the receive
 * port. Every read response on tx is checked against a queue of expected
 * tid and data pairs built from the register map.
 */
`timescale 1ns/1ps

module afu_top_tb;

    localparam int MMIO_FIFO_DEPTH = 16;
    localparam int NUM_KERNEL_CSRS = 8;
    localparam int KERNEL_RD_DEPTH = 4;
    localparam int DRAIN_LIMIT     = 200;

    // One expected read response
    typedef struct packed {
        afu_pkg::mmio_tid_t tid;
        afu_pkg::csr_data_t data;
    } expect_t;

    logic               pClk;
    logic               reset;
    logic               live;
    afu_pkg::host_rx_t  rx;
    afu_pkg::mmio_rsp_t tx;

    expect_t            exp_q [$];
    int                 exp_cnt;
    afu_pkg::mmio_tid_t exp_tid;
    afu_pkg::csr_data_t exp_data;
    afu_pkg::mmio_tid_t tid_next;
    // Reference copy of the writable kernel registers
    afu_pkg::csr_data_t model [1:NUM_KERNEL_CSRS-1];

    `include "tb_util.svh"

    afu_top #(
        .MMIO_FIFO_DEPTH (MMIO_FIFO_DEPTH),
        .NUM_KERNEL_CSRS (NUM_KERNEL_CSRS),
        .KERNEL_RD_DEPTH (KERNEL_RD_DEPTH)
    ) uut (
        .pClk  (pClk),
        .reset (reset),
        .rx    (rx),
        .tx    (tx)
    );

    initial
    begin
        pClk = 1'b0;
        forever #4 pClk = ~pClk;
    end

    // ==============================
    // Expected response queue
    // ==============================

    // Head of the queue is mirrored into plain signals for the assertions
    function automatic void refresh_head();
        exp_cnt = exp_q.size();
        if (exp_cnt != 0)
        begin
            exp_tid  = exp_q[0].tid;
            exp_data = exp_q[0].data;
        end
    endfunction

    // A response checked at the falling edge retires at the next rising edge
    always @(posedge pClk)
    begin
        if (live && tx.valid && exp_q.size() != 0)
        begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_tx_known: assert property (@(negedge pClk) disable iff (!live)
        !$isunknown(tx.valid))
    else
    begin
        $display("Response valid on tx is unknown after reset");
        err_count++;
    end

    // Covers the quiet period after reset and host-memory responses
    a_no_stray: assert property (@(negedge pClk) disable iff (!live)
        tx.valid |-> exp_cnt != 0)
    else
    begin
        $display("Read response with tid %h arrived while none was expected", tx.tid);
        err_count++;
    end

    a_rsp_tid: assert property (@(negedge pClk) disable iff (!live)
        (tx.valid && exp_cnt != 0) |-> tx.tid == exp_tid)
    else
    begin
        $display("ERROR tx.tid expected %h got %h", exp_tid, tx.tid);
        err_count++;
    end

    a_rsp_data: assert property (@(negedge pClk) disable iff (!live)
        (tx.valid && exp_cnt != 0) |-> tx.data == exp_data)
    else
    begin
        $display("ERROR tx.data expected %h got %h", exp_data, tx.data);
        err_count++;
    end

    // ==============================
    // Host stimulus
    // ==============================

    // Each call owns one cycle of the receive port
    task automatic drive_rx(input logic rd, input logic wr, input logic host_rsp,
                            input afu_pkg::mmio_addr_t addr, input afu_pkg::csr_data_t data);
        @(posedge pClk);
        #1;
        rx.mmio_rd_valid = rd;
        rx.mmio_wr_valid = wr;
        rx.rsp_valid     = host_rsp;
        rx.addr          = addr;
        rx.tid           = tid_next;
        rx.data          = data;
        if (rd || wr)
            tid_next++;
    endtask

    task automatic idle();
        @(posedge pClk);
        #1;
        rx = '0;
    endtask

    task automatic read_mmio(input afu_pkg::mmio_addr_t addr, input afu_pkg::csr_data_t value);
        exp_q.push_back('{tid: tid_next, data: value});
        refresh_head();
        drive_rx(1'b1, 1'b0, 1'b0, addr, '0);
    endtask

    task automatic write_mmio(input afu_pkg::mmio_addr_t addr, input afu_pkg::csr_data_t data);
        drive_rx(1'b0, 1'b1, 1'b0, addr, data);
    endtask

    // Host-memory traffic aimed at a live register address
    task automatic host_rsp(input afu_pkg::mmio_addr_t addr);
        drive_rx(1'b0, 1'b0, 1'b1, addr, rand64());
    endtask

    // Kernel register i sits two MMIO words after register i-1
    function automatic afu_pkg::mmio_addr_t kernel_addr(input int idx);
        return afu_pkg::KERNEL_CSR_BASE + afu_pkg::mmio_addr_t'(2 * idx);
    endfunction

    function automatic afu_pkg::csr_data_t kernel_expect(input int idx);
        if (idx == 0)
            return afu_pkg::KERNEL_VERSION;
        else if (idx < NUM_KERNEL_CSRS)
            return model[idx];
        else
            return '0;
    endfunction

    task automatic kernel_write(input int idx, input afu_pkg::csr_data_t data);
        if (idx >= 1 && idx < NUM_KERNEL_CSRS)
            model[idx] = data;
        write_mmio(kernel_addr(idx), data);
    endtask

    task automatic end_run();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        int err_before;
        int idx;
        reset    = 1'b1;
        live     = 1'b0;
        rx       = '0;
        tid_next = '0;
        refresh_head();
        for (int i = 1; i < NUM_KERNEL_CSRS; i++)
            model[i] = '0;
        repeat (3) @(posedge pClk);
        #1;
        reset = 1'b0;
        live  = 1'b1;

        // Internal reset is still draining here, tx must stay low throughout
        err_before = err_count;
        repeat (8) idle();
        finish_test("quiet after reset", err_before);

        err_before = err_count;
        read_mmio(16'h0000, afu_pkg::AFU_DFH);
        read_mmio(16'h0042, '0);
        write_mmio(16'h0000, rand64());
        write_mmio(16'h0042, rand64());
        read_mmio(16'h0000, afu_pkg::AFU_DFH);
        read_mmio(16'h0042, '0);
        idle();
        wait_drain(DRAIN_LIMIT, "header region reads");
        finish_test("header region", err_before);

        err_before = err_count;
        for (int i = 1; i < NUM_KERNEL_CSRS; i++)
            kernel_write(i, rand64());
        for (int i = 1; i < NUM_KERNEL_CSRS; i++)
            read_mmio(kernel_addr(i), kernel_expect(i));
        idle();
        wait_drain(DRAIN_LIMIT, "kernel register readback");
        finish_test("kernel write and readback", err_before);

        // Register 0 ignores writes, and so does everything past the end
        err_before = err_count;
        kernel_write(0, rand64());
        kernel_write(11, rand64());
        // Index 11 shares its low index bits with register 3
        read_mmio(kernel_addr(3), kernel_expect(3));
        read_mmio(kernel_addr(0), kernel_expect(0));
        read_mmio(kernel_addr(NUM_KERNEL_CSRS), kernel_expect(NUM_KERNEL_CSRS));
        read_mmio(kernel_addr(11), kernel_expect(11));
        idle();
        wait_drain(DRAIN_LIMIT, "version and range reads");
        finish_test("version and out of range", err_before);

        // More reads than the kernel read queue holds, streamed back to back
        err_before = err_count;
        for (int n = 0; n < 12; n++)
        begin
            if (n == 5)
                read_mmio(16'h0000, afu_pkg::AFU_DFH);
            else
            begin
                idx = int'(xorshift32() % 10);
                read_mmio(kernel_addr(idx), kernel_expect(idx));
            end
        end
        idle();
        wait_drain(DRAIN_LIMIT, "back to back reads");
        // A response past the twelfth would show up in this window
        repeat (4) idle();
        finish_test("back to back reads", err_before);

        err_before = err_count;
        kernel_write(3, rand64());
        host_rsp(kernel_addr(3));
        read_mmio(kernel_addr(3), kernel_expect(3));
        host_rsp(kernel_addr(3));
        host_rsp(16'h0000);
        for (int i = 1; i < NUM_KERNEL_CSRS; i++)
        begin
            host_rsp(kernel_addr(i));
            read_mmio(kernel_addr(i), kernel_expect(i));
        end
        idle();
        wait_drain(DRAIN_LIMIT, "reads mixed with host responses");
        // Any late response from host traffic would show up in this window
        repeat (8) idle();
        finish_test("host responses ignored", err_before);

        end_run();
    end

endmodule
